//--- Makefile
# Verilator build and run of the decompressor testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module tb_decompressor -f decompressor.f
	./obj_dir/Vtb_decompressor | tee sim.log
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- decompressor.f
+incdir+include
design/decomp_pkg.sv
design/input_fifo.sv
design/token_parser.sv
design/history_ram.sv
design/block_packer.sv
design/decomp_control.sv
design/decompressor.sv
sim/tb_decompressor.sv

//--- design/block_packer.sv
/* block packer
   gathers output bytes into bus words, flags last word and 64-byte block ends */
`include "decomp_cfg.svh"

module block_packer
	import decomp_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n_i,
	input  logic    job_active_i,
	input  len_t    decompression_length_i,
	input  byte_t   byte_i,
	input  logic    byte_valid_i,
	input  logic    wr_ready_i,
	output logic    stall_o,
	output word_t   data_o,
	output bvalid_t byte_valid_o,
	output logic    valid_o,
	output logic    last_o,
	output logic    block_out_o,
	output logic    job_out_o
);

	localparam int NB = `DECOMP_WORD_BYTES;
	localparam int CNT_W = $clog2(NB) + 1;
	localparam int BLK_W = $clog2(`DECOMP_BLOCK_WORDS);

	word_t fill_data_q;
	word_t nxt_data;
	word_t fin_data_q;
	logic [CNT_W-1:0] fill_cnt_q;
	logic [CNT_W-1:0] nxt_cnt;
	logic fill_last_q;
	logic nxt_last;
	bvalid_t nxt_bv;
	bvalid_t fin_bv_q;
	logic fin_valid_q;
	logic fin_last_q;
	len_t out_cnt_q; // bytes received this job
	logic [BLK_W-1:0] blk_cnt_q; // words accepted in the current block
	logic final_byte;
	logic accept;
	logic fin_free;
	logic move;
	logic block_end;

	assign final_byte = byte_valid_i && (out_cnt_q + 1'b1 == decompression_length_i);
	assign accept = fin_valid_q && wr_ready_i;
	assign fin_free = !fin_valid_q || accept;
	assign block_end = (blk_cnt_q == BLK_W'(`DECOMP_BLOCK_WORDS - 1)) || fin_last_q;

	// filling word with the incoming byte merged in
	always_comb begin
		nxt_data = fill_data_q;
		nxt_cnt = fill_cnt_q;
		nxt_last = fill_last_q;
		if (byte_valid_i) begin
			nxt_data[fill_cnt_q[CNT_W-2:0]*8 +: 8] = byte_i;
			nxt_cnt = fill_cnt_q + 1'b1;
			nxt_last = fill_last_q || final_byte;
		end
		for (int k = 0; k < NB; k++)
			nxt_bv[k] = (nxt_cnt > k);
	end

	assign move = ((nxt_cnt == CNT_W'(NB)) || nxt_last) && fin_free;

	// two slots left for the byte in the RAM and the op issued this cycle
	assign stall_o = fin_valid_q && (fill_cnt_q >= CNT_W'(NB - 2));

	assign data_o = fin_data_q;
	assign byte_valid_o = fin_bv_q;
	assign valid_o = fin_valid_q;
	assign last_o = fin_last_q;
	assign block_out_o = accept && block_end;
	assign job_out_o = accept && fin_last_q;

	always_ff @(posedge clk) begin
		fill_data_q <= nxt_data;
		if (move)
			fin_data_q <= nxt_data;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			fill_cnt_q <= '0;
			fill_last_q <= 1'b0;
			fin_valid_q <= 1'b0;
			fin_last_q <= 1'b0;
			fin_bv_q <= '0;
			out_cnt_q <= '0;
			blk_cnt_q <= '0;
		end else if (!job_active_i) begin
			fill_cnt_q <= '0;
			fill_last_q <= 1'b0;
			fin_valid_q <= 1'b0;
			fin_last_q <= 1'b0;
			fin_bv_q <= '0;
			out_cnt_q <= '0;
			blk_cnt_q <= '0;
		end else begin
			if (byte_valid_i)
				out_cnt_q <= out_cnt_q + 1'b1;
			if (move) begin
				fill_cnt_q <= '0;
				fill_last_q <= 1'b0;
				fin_valid_q <= 1'b1;
				fin_last_q <= nxt_last;
				fin_bv_q <= nxt_bv;
			end else begin
				fill_cnt_q <= nxt_cnt;
				fill_last_q <= nxt_last;
				if (accept) begin
					fin_valid_q <= 1'b0;
					fin_last_q <= 1'b0;
				end
			end
			if (accept)
				blk_cnt_q <= block_end ? '0 : blk_cnt_q + 1'b1;
		end
	end

endmodule

//--- design/decomp_control.sv
/* job control
   tracks one decompression job from start to the last accepted word */
module decomp_control
	import decomp_pkg::*;
(
	input  logic clk,
	input  logic arst_n_i,
	input  logic start_i,
	input  logic in_done_i,
	input  logic job_out_i,
	output logic job_active_o,
	output logic idle_o,
	output logic done_o
);

	job_state_t state_q;

	assign job_active_o = (state_q != JOB_IDLE);
	assign idle_o = (state_q == JOB_IDLE);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= JOB_IDLE;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				JOB_IDLE: begin
					if (start_i)
						state_q <= JOB_RUN;
				end
				JOB_RUN: begin
					// input may still be counted down when the last word leaves
					if (job_out_i) begin
						state_q <= JOB_IDLE;
						done_o <= 1'b1;
					end else if (in_done_i) begin
						state_q <= JOB_DRAIN;
					end
				end
				JOB_DRAIN: begin
					if (job_out_i) begin
						state_q <= JOB_IDLE;
						done_o <= 1'b1; // one cycle after the final word
					end
				end
				default: state_q <= JOB_IDLE;
			endcase
		end
	end

endmodule

//--- design/decomp_pkg.sv
/* decompressor package
   vector types and state encodings used across the decompressor */
`include "decomp_cfg.svh"

package decomp_pkg;

	typedef logic [7:0] byte_t; // one stream byte
	typedef logic [`DECOMP_WORD_BYTES*8-1:0] word_t;
	typedef logic [`DECOMP_WORD_BYTES-1:0] bvalid_t; // one bit per byte lane

	typedef logic [`DECOMP_HIST_AW-1:0] hist_addr_t;
	typedef logic [15:0] offset_t; // copy distance back into history
	typedef logic [`DECOMP_LEN_W-1:0] len_t;

	// token parser
	typedef enum logic [2:0] {
		PS_PREAMBLE,
		PS_TAG,
		PS_EXTRA1,
		PS_EXTRA2,
		PS_LITERAL,
		PS_COPY
	} parse_state_t;

	// job control
	typedef enum logic [1:0] {
		JOB_IDLE,
		JOB_RUN,
		JOB_DRAIN
	} job_state_t;

endpackage

//--- design/decompressor.sv
/* decompressor top
   single-lane Snappy stream decoder with 64-bit input and output words */
module decompressor
	import decomp_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n_i,
	input  word_t   data_i,
	input  logic    valid_i,
	input  logic    start_i,
	input  len_t    compression_length_i, // stream bytes incl. preamble
	input  len_t    decompression_length_i, // bytes to produce
	input  logic    wr_ready_i,
	output logic    data_fifo_almostfull_o,
	output logic    block_out_o,
	output logic    done_o,
	output logic    idle_o,
	output logic    last_o,
	output word_t   data_o,
	output bvalid_t byte_valid_o,
	output logic    valid_o
);

	word_t fifo_word;
	logic fifo_word_valid;
	logic word_rd;
	logic lit_we;
	byte_t lit_byte;
	logic copy_re;
	offset_t copy_off;
	logic in_done;
	byte_t hist_byte;
	logic hist_valid;
	logic stall;
	logic job_out;
	logic job_active;

	input_fifo u_input_fifo (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.wr_en_i       (valid_i),
		.wr_data_i     (data_i),
		.rd_en_i       (word_rd),
		.word_o        (fifo_word),
		.word_valid_o  (fifo_word_valid),
		.almost_full_o (data_fifo_almostfull_o)
	);

	token_parser u_token_parser (
		.clk                  (clk),
		.arst_n_i             (arst_n_i),
		.job_active_i         (job_active),
		.compression_length_i (compression_length_i),
		.word_i               (fifo_word),
		.word_valid_i         (fifo_word_valid),
		.stall_i              (stall),
		.word_rd_o            (word_rd),
		.lit_we_o             (lit_we),
		.lit_byte_o           (lit_byte),
		.copy_re_o            (copy_re),
		.copy_off_o           (copy_off),
		.in_done_o            (in_done)
	);

	history_ram u_history_ram (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.job_active_i (job_active),
		.lit_we_i     (lit_we),
		.lit_byte_i   (lit_byte),
		.copy_re_i    (copy_re),
		.copy_off_i   (copy_off),
		.out_byte_o   (hist_byte),
		.out_valid_o  (hist_valid)
	);

	block_packer u_block_packer (
		.clk                    (clk),
		.arst_n_i               (arst_n_i),
		.job_active_i           (job_active),
		.decompression_length_i (decompression_length_i),
		.byte_i                 (hist_byte),
		.byte_valid_i           (hist_valid),
		.wr_ready_i             (wr_ready_i),
		.stall_o                (stall),
		.data_o                 (data_o),
		.byte_valid_o           (byte_valid_o),
		.valid_o                (valid_o),
		.last_o                 (last_o),
		.block_out_o            (block_out_o),
		.job_out_o              (job_out)
	);

	decomp_control u_decomp_control (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.start_i      (start_i),
		.in_done_i    (in_done),
		.job_out_i    (job_out),
		.job_active_o (job_active),
		.idle_o       (idle_o),
		.done_o       (done_o)
	);

endmodule

//--- design/history_ram.sv
/* history RAM
   byte window of the decoded output, literal writes and copy reads with write-back */
module history_ram
	import decomp_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n_i,
	input  logic    job_active_i,
	input  logic    lit_we_i,
	input  byte_t   lit_byte_i,
	input  logic    copy_re_i,
	input  offset_t copy_off_i,
	output byte_t   out_byte_o,
	output logic    out_valid_o
);

	localparam int DEPTH = 1 << $bits(hist_addr_t);

	byte_t mem [DEPTH];
	hist_addr_t wr_ptr_q; // next byte position
	hist_addr_t wr_addr_q; // target of the op now leaving
	hist_addr_t rd_addr;
	logic is_copy_q;
	logic bypass_q;
	byte_t lit_q;
	byte_t rd_q;
	byte_t byp_q;
	logic op;

	assign op = lit_we_i || copy_re_i;
	assign rd_addr = wr_ptr_q - hist_addr_t'(copy_off_i);

	assign out_byte_o = !is_copy_q ? lit_q : (bypass_q ? byp_q : rd_q);

	// every output byte is written back one cycle after its op
	always_ff @(posedge clk) begin
		rd_q <= mem[rd_addr];
		lit_q <= lit_byte_i;
		byp_q <= out_byte_o; // byte being written this cycle
		if (op)
			wr_addr_q <= wr_ptr_q;
		if (out_valid_o)
			mem[wr_addr_q] <= out_byte_o;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			out_valid_o <= 1'b0;
			is_copy_q <= 1'b0;
			bypass_q <= 1'b0;
		end else if (!job_active_i) begin
			wr_ptr_q <= '0;
			out_valid_o <= 1'b0;
			is_copy_q <= 1'b0;
			bypass_q <= 1'b0;
		end else begin
			out_valid_o <= op;
			is_copy_q <= copy_re_i;
			// read hits the write still in flight, e.g. offset 1
			bypass_q <= copy_re_i && out_valid_o && (rd_addr == wr_addr_q);
			if (op)
				wr_ptr_q <= wr_ptr_q + 1'b1;
		end
	end

endmodule

//--- design/input_fifo.sv
/* input word FIFO
   first-word fall-through buffer for compressed words, with almost-full */
`include "decomp_cfg.svh"

module input_fifo
	import decomp_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n_i,
	input  logic  wr_en_i,
	input  word_t wr_data_i,
	input  logic  rd_en_i,
	output word_t word_o,
	output logic  word_valid_o,
	output logic  almost_full_o
);

	localparam int DEPTH = 1 << `DECOMP_FIFO_AW;

	word_t mem [DEPTH];
	logic [`DECOMP_FIFO_AW-1:0] wr_ptr_q;
	logic [`DECOMP_FIFO_AW-1:0] rd_ptr_q;
	logic [`DECOMP_FIFO_AW:0] count_q; // one extra bit for the full state
	logic do_wr;
	logic do_rd;

	assign do_wr = wr_en_i && !count_q[`DECOMP_FIFO_AW]; // top bit only set when full
	assign do_rd = rd_en_i && word_valid_o;

	assign word_o = mem[rd_ptr_q];
	assign word_valid_o = (count_q != '0);
	assign almost_full_o = (count_q >= `DECOMP_FIFO_AFULL);

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr_q] <= wr_data_i;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ; // both or neither, level unchanged
			endcase
		end
	end

endmodule

//--- design/token_parser.sv
/* token parser
   walks the compressed bytes, skips the length preamble and issues one byte op per cycle */
module token_parser
	import decomp_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n_i,
	input  logic    job_active_i,
	input  len_t    compression_length_i,
	input  word_t   word_i,
	input  logic    word_valid_i,
	input  logic    stall_i,
	output logic    word_rd_o,
	output logic    lit_we_o,
	output byte_t   lit_byte_o,
	output logic    copy_re_o,
	output offset_t copy_off_o,
	output logic    in_done_o
);

	localparam int IDX_W = $clog2($bits(bvalid_t));

	parse_state_t state_q;
	logic [IDX_W-1:0] byte_idx_q; // lane of the current byte
	len_t in_cnt_q; // compressed bytes consumed so far
	logic [6:0] rem_q; // bytes left in the current token
	logic two_byte_q;
	offset_t off_q;
	byte_t cur_byte;
	logic in_end;
	logic last_in;
	logic take;

	assign cur_byte = word_i[byte_idx_q*8 +: 8];
	assign in_end = (in_cnt_q == compression_length_i);
	assign last_in = (in_cnt_q + 1'b1 == compression_length_i);

	// a stream byte is consumed in every state except copy
	assign take = job_active_i && !stall_i && word_valid_i && !in_end && (state_q != PS_COPY);

	// pop on the top lane or on the final stream byte, the rest of that word is dropped
	assign word_rd_o = take && ((&byte_idx_q) || last_in);

	assign lit_we_o = take && (state_q == PS_LITERAL);
	assign lit_byte_o = cur_byte;
	assign copy_re_o = job_active_i && !stall_i && (state_q == PS_COPY);
	assign copy_off_o = off_q;
	assign in_done_o = job_active_i && in_end;

	always_ff @(posedge clk) begin
		if (take && state_q == PS_TAG)
			off_q[15:8] <= {5'd0, cur_byte[7:5]}; // high bits of a 1-byte-offset copy
		if (take && state_q == PS_EXTRA1)
			off_q[7:0] <= cur_byte;
		if (take && state_q == PS_EXTRA2)
			off_q[15:8] <= cur_byte;
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= PS_PREAMBLE;
			byte_idx_q <= '0;
			in_cnt_q <= '0;
			rem_q <= '0;
			two_byte_q <= 1'b0;
		end else if (!job_active_i) begin
			state_q <= PS_PREAMBLE;
			byte_idx_q <= '0;
			in_cnt_q <= '0;
			rem_q <= '0;
			two_byte_q <= 1'b0;
		end else begin
			if (take) begin
				in_cnt_q <= in_cnt_q + 1'b1;
				byte_idx_q <= word_rd_o ? '0 : byte_idx_q + 1'b1;
			end
			case (state_q)
				PS_PREAMBLE: begin
					if (take && !cur_byte[7]) // varint ends on a clear bit 7
						state_q <= PS_TAG;
				end
				PS_TAG: begin
					if (take) begin
						case (cur_byte[1:0])
							2'b00: begin
								rem_q <= {1'b0, cur_byte[7:2]} + 1'b1;
								state_q <= PS_LITERAL;
							end
							2'b01: begin
								rem_q <= 7'd4 + cur_byte[4:2];
								two_byte_q <= 1'b0;
								state_q <= PS_EXTRA1;
							end
							2'b10: begin
								rem_q <= {1'b0, cur_byte[7:2]} + 1'b1;
								two_byte_q <= 1'b1;
								state_q <= PS_EXTRA1;
							end
							default: ; // 4-byte offset copies are not supported
						endcase
					end
				end
				PS_EXTRA1: begin
					if (take)
						state_q <= two_byte_q ? PS_EXTRA2 : PS_COPY;
				end
				PS_EXTRA2: begin
					if (take)
						state_q <= PS_COPY;
				end
				PS_LITERAL: begin
					if (take) begin
						rem_q <= rem_q - 1'b1;
						if (rem_q == 7'd1)
							state_q <= PS_TAG;
					end
				end
				PS_COPY: begin
					if (copy_re_o) begin
						rem_q <= rem_q - 1'b1;
						if (rem_q == 7'd1)
							state_q <= PS_TAG;
					end
				end
				default: state_q <= PS_PREAMBLE;
			endcase
		end
	end

endmodule

//--- include/decomp_cfg.svh
/* decompressor configuration
   widths, depths and thresholds shared by the package and the RTL */
`ifndef DECOMP_CFG_SVH
`define DECOMP_CFG_SVH

// bytes carried by one bus word
`define DECOMP_WORD_BYTES 8

// history window of 4096 bytes
`define DECOMP_HIST_AW 12

// input FIFO holds 16 words
`define DECOMP_FIFO_AW 4

// fill level that raises almost-full
`define DECOMP_FIFO_AFULL 12

`define DECOMP_LEN_W 20 // job byte counters

// output words per 64-byte block
`define DECOMP_BLOCK_WORDS 8

`endif

//--- sim/tb_decompressor.sv
/* decompressor testbench
   directed Snappy streams checked against a reference expander */
module tb_decompressor
	import decomp_pkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TOTAL_BYTES = 21 + 58 + 300 + 130 + 24 + 40 + 200;
	localparam int TIMEOUT_CYCLES = 40 * TOTAL_BYTES;

	logic clk;
	logic arst_n;
	word_t data_i;
	logic valid_i;
	logic start_i;
	len_t compression_length_i;
	len_t decompression_length_i;
	logic wr_ready_i;
	logic data_fifo_almostfull_o;
	logic block_out_o;
	logic done_o;
	logic idle_o;
	logic last_o;
	word_t data_o;
	bvalid_t byte_valid_o;
	logic valid_o;

	integer seed = 32'hc48a541e;
	int val_errs = 0;
	int other_errs = 0;
	int cmd_kind[$]; // 0 literal, 1 copy with 1-byte offset, 2 copy with 2-byte offset
	int cmd_len[$];
	int cmd_off[$];
	byte_t comp_q[$]; // compressed stream
	byte_t exp_q[$]; // expected output bytes not yet seen
	int word_cnt;
	int blk_cnt;
	int done_cnt;
	logic job_done;
	logic hold_pend = 1'b0;
	logic last_acc = 1'b0; // final word was accepted in the previous cycle
	word_t hold_data;
	bvalid_t hold_bv;
	bvalid_t last_bv;

	decompressor decompressor_i (
		.clk                    (clk),
		.arst_n_i               (arst_n),
		.data_i                 (data_i),
		.valid_i                (valid_i),
		.start_i                (start_i),
		.compression_length_i   (compression_length_i),
		.decompression_length_i (decompression_length_i),
		.wr_ready_i             (wr_ready_i),
		.data_fifo_almostfull_o (data_fifo_almostfull_o),
		.block_out_o            (block_out_o),
		.done_o                 (done_o),
		.idle_o                 (idle_o),
		.last_o                 (last_o),
		.data_o                 (data_o),
		.byte_valid_o           (byte_valid_o),
		.valid_o                (valid_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_bvalid(input string name, input bvalid_t got, input bvalid_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			val_errs++;
			$display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_and_finish();
		$display("errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	task automatic add_cmd(input int kind, input int len, input int off);
		cmd_kind.push_back(kind);
		cmd_len.push_back(len);
		cmd_off.push_back(off);
	endtask

	// decode comp_q by the Snappy tag rules into exp_q
	task automatic expand_stream();
		int i;
		int len;
		int off;
		int shift;
		int ulen;
		byte_t t;
		exp_q.delete();
		i = 0;
		shift = 0;
		ulen = 0;
		do begin
			t = comp_q[i];
			ulen = ulen | (int'(t[6:0]) << shift);
			shift += 7;
			i++;
		end while (t[7]);
		while (i < comp_q.size()) begin
			t = comp_q[i];
			i++;
			off = 0;
			case (t[1:0])
				2'b00: len = int'(t[7:2]) + 1;
				2'b01: begin
					len = 4 + int'(t[4:2]);
					off = {t[7:5], comp_q[i]};
					i++;
				end
				2'b10: begin
					len = int'(t[7:2]) + 1;
					off = {comp_q[i + 1], comp_q[i]}; // little-endian
					i += 2;
				end
				default: begin
					other_errs++;
					$display("stream holds a tag kind the decoder does not support");
					len = 0;
				end
			endcase
			for (int k = 0; k < len; k++) begin
				if (t[1:0] == 2'b00) begin
					exp_q.push_back(comp_q[i]);
					i++;
				end else begin
					exp_q.push_back(exp_q[exp_q.size() - off]); // byte by byte, overlap ok
				end
			end
		end
		if (ulen != exp_q.size()) begin
			other_errs++;
			$display("preamble says %0d bytes but the stream expands to %0d", ulen, exp_q.size());
		end
	endtask

	// encode the command list as preamble plus tags, then expand it
	task automatic build_stream();
		int total;
		int v;
		byte_t b;
		total = 0;
		comp_q.delete();
		foreach (cmd_len[i])
			total += cmd_len[i];
		v = total;
		do begin
			b = {1'b0, v[6:0]};
			v = v >> 7;
			if (v != 0)
				b[7] = 1'b1; // more varint bytes follow
			comp_q.push_back(b);
		end while (v != 0);
		foreach (cmd_kind[i]) begin
			case (cmd_kind[i])
				0: begin
					comp_q.push_back({6'(cmd_len[i] - 1), 2'b00});
					repeat (cmd_len[i])
						comp_q.push_back(byte_t'(rand_below(256)));
				end
				1: begin
					comp_q.push_back({3'(cmd_off[i] >> 8), 3'(cmd_len[i] - 4), 2'b01});
					comp_q.push_back(byte_t'(cmd_off[i]));
				end
				default: begin
					comp_q.push_back({6'(cmd_len[i] - 1), 2'b10});
					comp_q.push_back(byte_t'(cmd_off[i]));
					comp_q.push_back(byte_t'(cmd_off[i] >> 8));
				end
			endcase
		end
		cmd_kind.delete();
		cmd_len.delete();
		cmd_off.delete();
		expand_stream();
	endtask

	// one accepted output word against the next expected bytes
	task automatic take_word();
		word_t ew;
		word_t mask;
		bvalid_t ebv;
		ew = '0;
		mask = '0;
		ebv = '0;
		if (exp_q.size() == 0) begin
			other_errs++;
			$display("output word %0d arrived after the last expected byte", word_cnt);
		end
		for (int k = 0; k < 8 && exp_q.size() > 0; k++) begin
			ew[k*8 +: 8] = exp_q.pop_front();
			mask[k*8 +: 8] = 8'hff;
			ebv[k] = 1'b1;
		end
		check_word("data_o", data_o & mask, ew);
		check_bvalid("byte_valid_o", byte_valid_o, ebv);
		check_flag("last_o", last_o, exp_q.size() == 0);
		check_flag("block_out_o", block_out_o, (word_cnt % 8 == 7) || exp_q.size() == 0);
		if (block_out_o)
			blk_cnt++;
		if (last_o)
			last_bv = byte_valid_o;
		word_cnt++;
	endtask

	always @(posedge clk) begin
		if (arst_n) begin
			if (hold_pend) begin // word must not move while back-pressured
				check_word("data_o", data_o, hold_data);
				check_bvalid("byte_valid_o", byte_valid_o, hold_bv);
				check_flag("valid_o", valid_o, 1'b1);
			end
			hold_pend = valid_o && !wr_ready_i;
			hold_data = data_o;
			hold_bv = byte_valid_o;
			check_flag("done_o", done_o, last_acc); // pulse follows the final word
			last_acc = valid_o && wr_ready_i && last_o;
			if (valid_o && wr_ready_i)
				take_word();
			else
				check_flag("block_out_o", block_out_o, 1'b0);
			if (done_o) begin
				done_cnt++;
				job_done = 1'b1;
			end
		end
	end

	// ready_mode: 0 always ready, 1 random, 2 held low for 200 cycles
	task automatic run_job(input int ready_mode, output logic saw_afull);
		word_t in_words[$];
		word_t w;
		int n_bytes;
		int cyc;
		w = '0;
		for (int i = 0; i < comp_q.size(); i++) begin
			w[(i % 8)*8 +: 8] = comp_q[i];
			if (i % 8 == 7 || i == comp_q.size() - 1) begin
				in_words.push_back(w);
				w = '0;
			end
		end
		n_bytes = exp_q.size();
		compression_length_i = len_t'(comp_q.size());
		decompression_length_i = len_t'(n_bytes);
		word_cnt = 0;
		blk_cnt = 0;
		done_cnt = 0;
		job_done = 1'b0;
		saw_afull = 1'b0;
		start_i = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		check_flag("idle_o", idle_o, 1'b0);
		cyc = 0;
		while (!job_done) begin
			saw_afull = saw_afull || data_fifo_almostfull_o;
			valid_i = 1'b0;
			if (in_words.size() > 0 && !data_fifo_almostfull_o) begin
				valid_i = 1'b1;
				data_i = in_words.pop_front();
			end
			case (ready_mode)
				0: wr_ready_i = 1'b1;
				1: wr_ready_i = (rand_below(2) == 0);
				default: wr_ready_i = (cyc >= 200);
			endcase
			cyc++;
			@(negedge clk);
		end
		valid_i = 1'b0;
		wr_ready_i = 1'b1;
		check_flag("idle_o", idle_o, 1'b1);
		repeat (3) @(negedge clk);
		if (done_cnt != 1 || exp_q.size() != 0 || in_words.size() != 0) begin
			other_errs++;
			$display("job ended with %0d done pulses, %0d bytes missing, %0d words unread",
				done_cnt, exp_q.size(), in_words.size());
		end
		if (blk_cnt != ((n_bytes + 7) / 8 + 7) / 8) begin
			other_errs++;
			$display("job of %0d bytes gave %0d block pulses", n_bytes, blk_cnt);
		end
	endtask

	task automatic literal_stream();
		logic afull;
		add_cmd(0, 21, 0);
		build_stream();
		run_job(0, afull);
		check_bvalid("byte_valid_o", last_bv, 8'h1f); // 21 bytes leave 5 in the last word
	endtask

	task automatic copy_kinds();
		logic afull;
		add_cmd(0, 8, 0);
		add_cmd(1, 6, 5);
		add_cmd(2, 10, 1); // overlapping run
		add_cmd(2, 20, 12);
		add_cmd(0, 3, 0);
		add_cmd(1, 11, 2);
		build_stream();
		run_job(0, afull);
	endtask

	task automatic random_mix_backpressure();
		int made;
		int len;
		int pick;
		logic afull;
		made = 0;
		while (made < 300) begin
			pick = rand_below(3);
			if (made == 0 || pick == 0) begin
				len = 1 + rand_below(60);
				len = (len > 300 - made) ? 300 - made : len;
				add_cmd(0, len, 0);
			end else if (pick == 1 && 300 - made >= 4) begin
				len = 4 + rand_below(8);
				len = (len > 300 - made) ? 300 - made : len;
				add_cmd(1, len, 1 + rand_below(made));
			end else begin
				len = 1 + rand_below(64);
				len = (len > 300 - made) ? 300 - made : len;
				add_cmd(2, len, 1 + rand_below(made));
			end
			made += len;
		end
		build_stream();
		run_job(1, afull);
	endtask

	task automatic block_pulse_count();
		logic afull;
		add_cmd(0, 60, 0);
		add_cmd(0, 40, 0);
		add_cmd(2, 30, 64);
		build_stream();
		run_job(0, afull); // 17 words, pulses on 8, 16 and 17
	endtask

	task automatic back_to_back_jobs();
		logic afull;
		add_cmd(0, 16, 0);
		add_cmd(1, 8, 16);
		build_stream();
		run_job(0, afull);
		add_cmd(0, 5, 0);
		add_cmd(2, 35, 3);
		build_stream();
		run_job(0, afull); // second job right after done
	endtask

	task automatic input_flow_control();
		logic afull;
		repeat (3)
			add_cmd(0, 60, 0);
		add_cmd(0, 20, 0);
		build_stream();
		run_job(2, afull);
		if (!afull) begin
			other_errs++;
			$display("input FIFO never reported almost-full while output was held");
		end
	endtask

	initial begin
		arst_n = 1'b0;
		data_i = '0;
		valid_i = 1'b0;
		start_i = 1'b0;
		compression_length_i = '0;
		decompression_length_i = '0;
		wr_ready_i = 1'b1;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		check_flag("idle_o", idle_o, 1'b1);
		check_flag("valid_o", valid_o, 1'b0);
		check_flag("done_o", done_o, 1'b0);
		check_flag("last_o", last_o, 1'b0);
		check_flag("data_fifo_almostfull_o", data_fifo_almostfull_o, 1'b0);
		literal_stream();
		copy_kinds();
		random_mix_backpressure();
		block_pulse_count();
		back_to_back_jobs();
		input_flow_control();
		report_and_finish();
	end

	// run limit
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		other_errs++;
		$display("timeout after %0d cycles without finishing the tests", TIMEOUT_CYCLES);
		report_and_finish();
	end

endmodule
